// File: common/rv_pkg.sv
// rv_pkg: word types, opcode/format/alu/branch/memory enums and the decoded control struct
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_imm32  = 7'b0011011,
    op_reg    = 7'b0110011,
    op_reg32  = 7'b0111011,
    op_system = 7'b1110011
  } opcode_e;

  // immediate format select
  typedef enum logic [2:0] {
    fmt_i = 3'b000,
    fmt_u = 3'b001,
    fmt_s = 3'b010,
    fmt_b = 3'b011,
    fmt_j = 3'b100,
    fmt_r = 3'b111
  } imm_fmt_e;

  typedef enum logic [3:0] {
    alu_add      = 4'b0000,
    alu_sll      = 4'b0001,
    alu_copy_imm = 4'b0011,
    alu_or       = 4'b0110,
    alu_sub      = 4'b1000,
    alu_sltu     = 4'b1010,
    alu_div      = 4'b1011,
    alu_mul      = 4'b1100,
    alu_rem      = 4'b1101,
    alu_ebreak   = 4'b1110,
    alu_invalid  = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_e;

  // s = signed, u = unsigned; stores use the signed codes
  typedef enum logic [2:0] {
    mem_sb   = 3'b000,
    mem_ub   = 3'b001,
    mem_sh   = 3'b010,
    mem_uh   = 3'b011,
    mem_sw   = 3'b100,
    mem_uw   = 3'b101,
    mem_sd   = 3'b110,
    mem_none = 3'b111
  } mem_op_e;

  typedef struct packed {
    reg_idx_t   ra;
    reg_idx_t   rb;
    reg_idx_t   rd;
    xlen_t      imm;
    branch_e    branch;
    logic       alu_a_pc;    // 0 rs1, 1 pc
    logic [1:0] alu_b_src;   // 00 rs2, 01 imm, 10 const 4
    alu_op_e    alu_op;
    logic       word_cut;
    logic       reg_wr;
    logic       mem_to_reg;
    logic       mem_wr;
    mem_op_e    mem_op;
  } ctrl_t;

endpackage

// File: hdl/rv_alu.sv
// rv_alu: 64-bit ALU with 32-bit word mode and signed 32-bit mul/div/rem
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  alu_op_e i_op,
  input  logic    i_word_cut,
  input  xlen_t   i_a,
  input  xlen_t   i_b,
  output xlen_t   o_result
);

  xlen_t              a_op, b_op, res;
  logic signed [31:0] a_w, b_w;
  logic signed [31:0] quo_w, rem_w;
  logic        [31:0] mul_w, div_w, mod_w;

  // operands cut to 32 bits in word mode
  assign a_op = i_word_cut ? {32'b0, i_a[31:0]} : i_a;
  assign b_op = i_word_cut ? {32'b0, i_b[31:0]} : i_b;

  assign a_w = i_a[31:0];
  assign b_w = i_b[31:0];

  always_comb begin
    mul_w = a_w * b_w;   // low half is sign-agnostic
    quo_w = a_w / b_w;
    rem_w = a_w % b_w;
    if (b_w == 32'sd0) begin
      div_w = '1;
      mod_w = a_w;   // remainder is the dividend
    end else begin
      div_w = quo_w;
      mod_w = rem_w;
    end
  end

  always_comb begin
    case (i_op)
      alu_copy_imm: res = b_op;
      alu_add:      res = a_op + b_op;
      alu_sub:      res = a_op - b_op;
      alu_sltu:     res = {63'b0, a_op < b_op};
      alu_or:       res = a_op | b_op;
      alu_sll:      res = a_op << b_op[5:0];   // shamt is imm[5:0]
      alu_mul:      res = {{32{mul_w[31]}}, mul_w};
      alu_div:      res = {{32{div_w[31]}}, div_w};
      alu_rem:      res = {{32{mod_w[31]}}, mod_w};
      default:      res = '0;   // ebreak, invalid
    endcase
  end

  assign o_result = i_word_cut ? {{32{res[31]}}, res[31:0]} : res;

endmodule

// File: hdl/rv_core.sv
// rv_core: single-cycle RV64 core top, unit wiring, operand and writeback select
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  inst_t      i_inst,
  input  xlen_t      i_dmem_rdata,
  output xlen_t      o_pc,
  output xlen_t      o_dmem_addr,
  output xlen_t      o_dmem_wdata,
  output logic [7:0] o_dmem_wmask,
  output logic       o_dmem_we,
  output logic       o_halt
);

  ctrl_t ctrl;
  xlen_t rs1, rs2, alu_a, alu_b, alu_res, load_data, wb_data;
  logic  wr_ok, reg_we, mem_we;

  rv_idu idu_i (
    .i_inst (i_inst),
    .o_ctrl (ctrl)
  );

  assign wr_ok  = !o_halt && !i_rst;   // no side effects once halted
  assign reg_we = ctrl.reg_wr && wr_ok;
  assign mem_we = ctrl.mem_wr && wr_ok;

  rv_regfile regfile_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_ra    (ctrl.ra),
    .i_rb    (ctrl.rb),
    .i_rd    (ctrl.rd),
    .i_we    (reg_we),
    .i_wdata (wb_data),
    .o_rs1   (rs1),
    .o_rs2   (rs2)
  );

  assign alu_a = ctrl.alu_a_pc ? o_pc : rs1;

  always_comb begin
    case (ctrl.alu_b_src)
      2'b00:   alu_b = rs2;
      2'b01:   alu_b = ctrl.imm;
      2'b10:   alu_b = 64'd4;   // link address
      default: alu_b = '0;
    endcase
  end

  rv_alu alu_i (
    .i_op       (ctrl.alu_op),
    .i_word_cut (ctrl.word_cut),
    .i_a        (alu_a),
    .i_b        (alu_b),
    .o_result   (alu_res)
  );

  rv_lsu lsu_i (
    .i_addr       (alu_res),
    .i_wdata      (rs2),
    .i_mem_op     (ctrl.mem_op),
    .i_mem_wr     (mem_we),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_wmask (o_dmem_wmask),
    .o_load_data  (load_data)
  );

  assign o_dmem_we = mem_we;
  assign wb_data   = ctrl.mem_to_reg ? load_data : alu_res;

  rv_ifu #(
    .RESET_PC (RESET_PC)
  ) ifu_i (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_branch (ctrl.branch),
    .i_ebreak (ctrl.alu_op == alu_ebreak),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .i_imm    (ctrl.imm),
    .o_pc     (o_pc),
    .o_halt   (o_halt)
  );

endmodule

// File: hdl/rv_ifu.sv
// rv_ifu: PC register, branch decision, next-PC select and halt flag
`timescale 1ns/1ps

module rv_ifu import rv_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  branch_e i_branch,
  input  logic    i_ebreak,
  input  xlen_t   i_rs1,
  input  xlen_t   i_rs2,
  input  xlen_t   i_imm,
  output xlen_t   o_pc,
  output logic    o_halt
);

  xlen_t pc_q, next_pc, jalr_sum;
  logic  halt_q, taken;

  always_comb begin
    case (i_branch)
      br_jal:  taken = 1'b1;
      br_beq:  taken = (i_rs1 == i_rs2);
      br_bne:  taken = (i_rs1 != i_rs2);
      br_bltu: taken = (i_rs1 < i_rs2);
      br_bgeu: taken = (i_rs1 >= i_rs2);
      default: taken = 1'b0;   // jalr handled below
    endcase
  end

  assign jalr_sum = i_rs1 + i_imm;

  always_comb begin
    if (i_branch == br_jalr) begin
      next_pc = {jalr_sum[63:1], 1'b0};
    end else if (taken) begin
      next_pc = pc_q + i_imm;
    end else begin
      next_pc = pc_q + 64'd4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q   <= RESET_PC;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      halt_q <= i_ebreak;
      if (!i_ebreak) begin
        pc_q <= next_pc;   // pc parks on ebreak
      end
    end
  end

  assign o_pc   = pc_q;
  assign o_halt = halt_q;

endmodule

// File: hdl/rv_lsu.sv
// rv_lsu: store lane alignment, byte mask and load lane extraction with extension
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  xlen_t      i_addr,
  input  xlen_t      i_wdata,
  input  mem_op_e    i_mem_op,
  input  logic       i_mem_wr,
  input  xlen_t      i_dmem_rdata,
  output xlen_t      o_dmem_addr,
  output xlen_t      o_dmem_wdata,
  output logic [7:0] o_dmem_wmask,
  output xlen_t      o_load_data
);

  logic [2:0] off;
  logic [5:0] lane_sh;
  logic [7:0] size_mask;
  xlen_t      rd_lane;

  assign off     = i_addr[2:0];
  assign lane_sh = {off, 3'b000};   // byte offset in bits

  assign o_dmem_addr  = {i_addr[63:3], 3'b000};
  assign o_dmem_wdata = i_wdata << lane_sh;

  always_comb begin
    case (i_mem_op)
      mem_sb, mem_ub: size_mask = 8'h01;
      mem_sh, mem_uh: size_mask = 8'h03;
      mem_sw, mem_uw: size_mask = 8'h0f;
      mem_sd:         size_mask = 8'hff;
      default:        size_mask = 8'h00;
    endcase
  end

  assign o_dmem_wmask = i_mem_wr ? (size_mask << off) : 8'h00;

  assign rd_lane = i_dmem_rdata >> lane_sh;

  always_comb begin
    case (i_mem_op)
      mem_sb:  o_load_data = {{56{rd_lane[7]}}, rd_lane[7:0]};
      mem_ub:  o_load_data = {56'b0, rd_lane[7:0]};
      mem_sh:  o_load_data = {{48{rd_lane[15]}}, rd_lane[15:0]};
      mem_uh:  o_load_data = {48'b0, rd_lane[15:0]};
      mem_sw:  o_load_data = {{32{rd_lane[31]}}, rd_lane[31:0]};
      mem_uw:  o_load_data = {32'b0, rd_lane[31:0]};
      mem_sd:  o_load_data = rd_lane;
      default: o_load_data = '0;
    endcase
  end

endmodule

// File: hdl/rv_regfile.sv
// rv_regfile: 32 x 64-bit register file, two async reads, one sync write, x0 reads zero
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  reg_idx_t i_ra,
  input  reg_idx_t i_rb,
  input  reg_idx_t i_rd,
  input  logic     i_we,
  input  xlen_t    i_wdata,
  output xlen_t    o_rs1,
  output xlen_t    o_rs2
);

  xlen_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != 5'd0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1 = (i_ra == 5'd0) ? '0 : regs[i_ra];   // x0 hard-wired
  assign o_rs2 = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

// File: idu/rv_idu.sv
// rv_idu: instruction decoder with immediate generation and control decode
`timescale 1ns/1ps

module rv_idu import rv_pkg::*; (
  input  inst_t i_inst,
  output ctrl_t o_ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  imm_fmt_e   fmt;
  xlen_t      imm_i, imm_u, imm_s, imm_b, imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    fmt               = fmt_r;
    o_ctrl.ra         = i_inst[19:15];
    o_ctrl.rb         = i_inst[24:20];
    o_ctrl.rd         = i_inst[11:7];
    o_ctrl.branch     = br_none;
    o_ctrl.alu_a_pc   = 1'b0;
    o_ctrl.alu_b_src  = 2'b00;
    o_ctrl.alu_op     = alu_invalid;
    o_ctrl.word_cut   = 1'b0;
    o_ctrl.reg_wr     = 1'b0;   // undecoded -> no-op
    o_ctrl.mem_to_reg = 1'b0;
    o_ctrl.mem_wr     = 1'b0;
    o_ctrl.mem_op     = mem_none;

    case (opcode)
      op_lui: begin
        fmt              = fmt_u;
        o_ctrl.alu_op    = alu_copy_imm;
        o_ctrl.alu_b_src = 2'b01;
        o_ctrl.reg_wr    = 1'b1;
      end
      op_auipc: begin
        fmt              = fmt_u;
        o_ctrl.alu_op    = alu_add;
        o_ctrl.alu_a_pc  = 1'b1;
        o_ctrl.alu_b_src = 2'b01;
        o_ctrl.reg_wr    = 1'b1;
      end
      op_jal: begin
        fmt              = fmt_j;
        o_ctrl.alu_op    = alu_add;
        o_ctrl.alu_a_pc  = 1'b1;
        o_ctrl.alu_b_src = 2'b10;   // link = pc + 4
        o_ctrl.branch    = br_jal;
        o_ctrl.reg_wr    = 1'b1;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          fmt              = fmt_i;
          o_ctrl.alu_op    = alu_add;
          o_ctrl.alu_a_pc  = 1'b1;
          o_ctrl.alu_b_src = 2'b10;
          o_ctrl.branch    = br_jalr;
          o_ctrl.reg_wr    = 1'b1;
        end
      end
      op_branch: begin
        fmt           = fmt_b;
        o_ctrl.alu_op = alu_sub;
        case (funct3)
          3'b000:  o_ctrl.branch = br_beq;
          3'b001:  o_ctrl.branch = br_bne;
          3'b110:  o_ctrl.branch = br_bltu;
          3'b111:  o_ctrl.branch = br_bgeu;
          default: o_ctrl.branch = br_none;
        endcase
      end
      op_load: begin
        fmt              = fmt_i;
        o_ctrl.alu_op    = alu_add;
        o_ctrl.alu_b_src = 2'b01;
        case (funct3)
          3'b001:  o_ctrl.mem_op = mem_sh;   // lh
          3'b101:  o_ctrl.mem_op = mem_uh;   // lhu
          3'b010:  o_ctrl.mem_op = mem_sw;   // lw
          3'b100:  o_ctrl.mem_op = mem_ub;   // lbu
          3'b011:  o_ctrl.mem_op = mem_sd;   // ld
          default: o_ctrl.mem_op = mem_none;
        endcase
        o_ctrl.reg_wr     = (o_ctrl.mem_op != mem_none);
        o_ctrl.mem_to_reg = (o_ctrl.mem_op != mem_none);
      end
      op_store: begin
        fmt              = fmt_s;
        o_ctrl.alu_op    = alu_add;
        o_ctrl.alu_b_src = 2'b01;
        case (funct3)
          3'b000:  o_ctrl.mem_op = mem_sb;
          3'b001:  o_ctrl.mem_op = mem_sh;
          3'b010:  o_ctrl.mem_op = mem_sw;
          3'b011:  o_ctrl.mem_op = mem_sd;
          default: o_ctrl.mem_op = mem_none;
        endcase
        o_ctrl.mem_wr = (o_ctrl.mem_op != mem_none);
      end
      op_imm: begin
        fmt              = fmt_i;
        o_ctrl.alu_b_src = 2'b01;
        o_ctrl.reg_wr    = 1'b1;
        case (funct3)
          3'b000: o_ctrl.alu_op = alu_add;    // addi
          3'b011: o_ctrl.alu_op = alu_sltu;   // sltiu
          3'b001: begin
            if (funct7[6:1] == 6'b000000) begin
              o_ctrl.alu_op = alu_sll;
            end else begin
              o_ctrl.reg_wr = 1'b0;
            end
          end
          default: o_ctrl.reg_wr = 1'b0;
        endcase
      end
      op_imm32: begin
        if (funct3 == 3'b000) begin   // addiw
          fmt              = fmt_i;
          o_ctrl.alu_op    = alu_add;
          o_ctrl.alu_b_src = 2'b01;
          o_ctrl.word_cut  = 1'b1;
          o_ctrl.reg_wr    = 1'b1;
        end
      end
      op_reg: begin
        o_ctrl.reg_wr = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_ctrl.alu_op = alu_add;
          {7'b0100000, 3'b000}: o_ctrl.alu_op = alu_sub;
          {7'b0000000, 3'b110}: o_ctrl.alu_op = alu_or;
          default:              o_ctrl.reg_wr = 1'b0;
        endcase
      end
      op_reg32: begin
        o_ctrl.reg_wr   = 1'b1;
        o_ctrl.word_cut = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_ctrl.alu_op = alu_add;   // addw
          {7'b0000001, 3'b000}: o_ctrl.alu_op = alu_mul;
          {7'b0000001, 3'b100}: o_ctrl.alu_op = alu_div;
          {7'b0000001, 3'b110}: o_ctrl.alu_op = alu_rem;
          default: begin
            o_ctrl.reg_wr   = 1'b0;
            o_ctrl.word_cut = 1'b0;
          end
        endcase
      end
      op_system: begin
        if (funct3 == 3'b000 && i_inst[31:20] == 12'h001) begin
          fmt           = fmt_i;
          o_ctrl.alu_op = alu_ebreak;
        end
      end
      default: ;
    endcase

    case (fmt)
      fmt_i:   o_ctrl.imm = imm_i;
      fmt_u:   o_ctrl.imm = imm_u;
      fmt_s:   o_ctrl.imm = imm_s;
      fmt_b:   o_ctrl.imm = imm_b;
      fmt_j:   o_ctrl.imm = imm_j;
      default: o_ctrl.imm = '0;   // r-type has none
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_core -f verilog.f -o sim_core

./obj_dir/sim_core > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0

// File: test/core_asserts.sv
// core_asserts: concurrent protocol checks on rv_core ports, attached by bind
`timescale 1ns/1ps

module core_asserts import rv_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input logic       i_clk,
  input logic       i_rst,
  input xlen_t      o_pc,
  input logic [7:0] o_dmem_wmask,
  input logic       o_dmem_we,
  input logic       o_halt
);

  pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) o_pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  we_has_mask: assert property (@(posedge i_clk) o_dmem_we |-> o_dmem_wmask != 8'h00)
    else $error("write strobe with empty mask");

  no_write_halted: assert property (@(posedge i_clk) o_halt |-> !o_dmem_we)
    else $error("write while halted");

  pc_after_reset: assert property (@(posedge i_clk) i_rst |=> o_pc == RESET_PC)
    else $error("pc not at reset vector");   // one edge after reset

endmodule

bind rv_core core_asserts #(
  .RESET_PC (RESET_PC)
) asserts_i (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .o_pc         (o_pc),
  .o_dmem_wmask (o_dmem_wmask),
  .o_dmem_we    (o_dmem_we),
  .o_halt       (o_halt)
);

// File: test/tb_core.sv
// tb_core: memory models, instruction encoders, directed tests, compare tasks, timeout
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

  localparam xlen_t RESET_PC    = 64'h0000_0000_8000_0000;
  localparam xlen_t BASE        = 64'h0000_0000_0000_1000;   // data area, x5 holds it
  localparam int    N_TESTS     = 6;
  localparam int    CYCLE_LIMIT = N_TESTS * (40 + 8);

  logic       i_clk;
  logic       i_rst;
  inst_t      i_inst;
  xlen_t      i_dmem_rdata;
  xlen_t      o_pc, o_dmem_addr, o_dmem_wdata;
  logic [7:0] o_dmem_wmask;
  logic       o_dmem_we, o_halt;

  inst_t prog [$];
  inst_t imem [256];
  xlen_t dmem [256];
  xlen_t trace [$];
  bit    tracing;
  int    val_errs;
  int    other_errs;
  int    cycles;
  logic [63:0] rng;

  rv_core dut_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_inst       (i_inst),
    .i_dmem_rdata (i_dmem_rdata),
    .o_pc         (o_pc),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_wmask (o_dmem_wmask),
    .o_dmem_we    (o_dmem_we),
    .o_halt       (o_halt)
  );

  always #4 i_clk = ~i_clk;

  // instruction port, updated just after the edge
  always @(posedge i_clk) begin
    #1 i_inst = imem[8'((o_pc - RESET_PC) >> 2)];
  end

  assign i_dmem_rdata = dmem[o_dmem_addr[10:3]];

  always @(posedge i_clk) begin
    if (o_dmem_we) begin
      for (int b = 0; b < 8; b++) begin
        if (o_dmem_wmask[b]) begin
          dmem[o_dmem_addr[10:3]][8*b +: 8] <= o_dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  always @(negedge i_clk) begin
    if (i_rst && o_dmem_we) begin
      other_errs++;
      $display("store strobe was high during reset at %0t", $time);
    end
    if (tracing && !i_rst && !o_halt) begin
      trace.push_back(o_pc);
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] xorshift(logic [63:0] x);
    logic [63:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 7);
    s = s ^ (s << 17);
    return s;
  endfunction

  function automatic xlen_t fill_word(xlen_t addr);
    return {addr[31:0] ^ 32'h5A3C_96E1, ~addr[31:0]};
  endfunction

  function automatic xlen_t pc_at(int k);
    return RESET_PC + 64'(k) * 64'd4;
  endfunction

  function automatic xlen_t sext32(logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic inst_t rtype(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t itype(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t stype(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t btype(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t utype(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t jtype(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // expected doubleword after a narrow store into old
  function automatic xlen_t merge_lane(xlen_t old, xlen_t data, int bytes, int off);
    xlen_t r;
    r = old;
    for (int b = 0; b < bytes; b++) begin
      r[8*(off+b) +: 8] = data[8*b +: 8];
    end
    return r;
  endfunction

  function automatic xlen_t extract(xlen_t word, int off, int bytes, bit sgn);
    xlen_t r;
    r = '0;
    for (int b = 0; b < bytes; b++) begin
      r[8*b +: 8] = word[8*(off+b) +: 8];
    end
    if (sgn && r[8*bytes-1]) begin
      for (int i = 8*bytes; i < 64; i++) begin
        r[i] = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic check_pc(xlen_t got, xlen_t exp, string msg);
    if (got !== exp) begin
      val_errs++;
      $display("FAIL %0t: %s pc %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_mem(xlen_t addr, xlen_t exp, string msg);
    xlen_t got;
    got = dmem[addr[10:3]];
    if (got !== exp) begin
      val_errs++;
      $display("FAIL %0t: %s mem[%h] %h, expected %h", $time, msg, addr, got, exp);
    end
  endtask

  task automatic check_halt(logic got, logic exp, string msg);
    if (got !== exp) begin
      val_errs++;
      $display("FAIL %0t: %s halt %b, expected %b", $time, msg, got, exp);
    end
  endtask

  // hold reset, load memories, release
  task automatic start_program();
    @(posedge i_clk);
    #1 i_rst = 1'b1;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0013;
      dmem[i] = fill_word(BASE + 64'(i) * 64'd8);
    end
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end
    trace.delete();
    repeat (8) @(posedge i_clk);
    #1 i_rst = 1'b0;
  endtask

  task automatic wait_halt();
    while (!o_halt) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic test_reset();
    prog.delete();
    prog.push_back(stype(12'd0, 5'd0, 5'd0, 3'b011));   // sits on the port during reset
    prog.push_back(32'h0010_0073);
    start_program();
    check_pc(o_pc, RESET_PC, "after reset");
    check_halt(o_halt, 1'b0, "after reset");
    check_mem(BASE + 0, fill_word(BASE + 0), "store during reset");
    wait_halt();
  endtask

  task automatic test_alu();
    xlen_t x6, x7, x8;
    x6 = 64'h0000_0000_1234_5000;
    x7 = pc_at(3) + 64'h1000;
    x8 = 64'hFFFF_FFFF_FFFF_FFFB;
    prog.delete();
    prog.push_back(utype(20'h00001, 5'd5, 7'b0110111));                  // lui x5
    prog.push_back(utype(20'h12345, 5'd6, 7'b0110111));
    prog.push_back(stype(12'd0, 5'd6, 5'd5, 3'b011));
    prog.push_back(utype(20'h00001, 5'd7, 7'b0010111));                  // auipc
    prog.push_back(stype(12'd8, 5'd7, 5'd5, 3'b011));
    prog.push_back(itype(12'hFFB, 5'd0, 3'b000, 5'd8, 7'b0010011));      // addi -5
    prog.push_back(stype(12'd16, 5'd8, 5'd5, 3'b011));
    prog.push_back(rtype(7'h00, 5'd8, 5'd6, 3'b000, 5'd9, 7'b0110011));
    prog.push_back(stype(12'd24, 5'd9, 5'd5, 3'b011));
    prog.push_back(rtype(7'h20, 5'd8, 5'd6, 3'b000, 5'd10, 7'b0110011));
    prog.push_back(stype(12'd32, 5'd10, 5'd5, 3'b011));
    prog.push_back(rtype(7'h00, 5'd8, 5'd6, 3'b110, 5'd11, 7'b0110011));
    prog.push_back(stype(12'd40, 5'd11, 5'd5, 3'b011));
    prog.push_back(itype(12'hFFF, 5'd6, 3'b011, 5'd12, 7'b0010011));     // sltiu
    prog.push_back(stype(12'd48, 5'd12, 5'd5, 3'b011));
    prog.push_back(itype(12'd40, 5'd8, 3'b001, 5'd13, 7'b0010011));      // slli
    prog.push_back(stype(12'd56, 5'd13, 5'd5, 3'b011));
    prog.push_back(32'h0010_0073);
    start_program();
    wait_halt();
    check_mem(BASE + 0, x6, "lui");
    check_mem(BASE + 8, x7, "auipc");
    check_mem(BASE + 16, x8, "addi");
    check_mem(BASE + 24, x6 + x8, "add");
    check_mem(BASE + 32, x6 - x8, "sub");
    check_mem(BASE + 40, x6 | x8, "or");
    check_mem(BASE + 48, 64'd1, "sltiu");
    check_mem(BASE + 56, x8 << 40, "slli");
  endtask

  task automatic test_word_ops();
    xlen_t a, b;
    logic [11:0] imm;
    logic signed [31:0] sa, sb;
    rng = xorshift(rng);
    a = rng;
    rng = xorshift(rng);
    b = rng;
    rng = xorshift(rng);
    imm = rng[11:0];
    sa = a[31:0];
    sb = b[31:0];
    prog.delete();
    prog.push_back(utype(20'h00001, 5'd5, 7'b0110111));
    prog.push_back(itype(12'd128, 5'd5, 3'b011, 5'd6, 7'b0000011));      // ld a
    prog.push_back(itype(12'd136, 5'd5, 3'b011, 5'd7, 7'b0000011));      // ld b
    prog.push_back(rtype(7'h00, 5'd7, 5'd6, 3'b000, 5'd8, 7'b0111011));
    prog.push_back(itype(imm, 5'd6, 3'b000, 5'd9, 7'b0011011));
    prog.push_back(rtype(7'h01, 5'd7, 5'd6, 3'b000, 5'd10, 7'b0111011));
    prog.push_back(rtype(7'h01, 5'd7, 5'd6, 3'b100, 5'd11, 7'b0111011));
    prog.push_back(rtype(7'h01, 5'd7, 5'd6, 3'b110, 5'd12, 7'b0111011));
    prog.push_back(rtype(7'h01, 5'd0, 5'd6, 3'b100, 5'd13, 7'b0111011)); // divide by x0
    prog.push_back(rtype(7'h01, 5'd0, 5'd6, 3'b110, 5'd14, 7'b0111011));
    for (int r = 8; r <= 14; r++) begin
      prog.push_back(stype(12'(8 * (r - 8)), 5'(r), 5'd5, 3'b011));
    end
    prog.push_back(32'h0010_0073);
    start_program();
    dmem[16] = a;
    dmem[17] = b;
    wait_halt();
    check_mem(BASE + 0, sext32(a[31:0] + b[31:0]), "addw");
    check_mem(BASE + 8, sext32(a[31:0] + {{20{imm[11]}}, imm}), "addiw");
    check_mem(BASE + 16, sext32(a[31:0] * b[31:0]), "mulw");
    if (sb == 0) begin
      check_mem(BASE + 24, '1, "divw");
      check_mem(BASE + 32, sext32(a[31:0]), "remw");
    end else begin
      check_mem(BASE + 24, sext32(sa / sb), "divw");
      check_mem(BASE + 32, sext32(sa % sb), "remw");
    end
    check_mem(BASE + 40, '1, "divw by zero");
    check_mem(BASE + 48, sext32(a[31:0]), "remw by zero");
  endtask

  task automatic test_mem();
    xlen_t p;
    p = 64'hF1E2_D3C4_B5A6_9788;
    prog.delete();
    prog.push_back(utype(20'h00001, 5'd5, 7'b0110111));
    prog.push_back(itype(12'd128, 5'd5, 3'b011, 5'd6, 7'b0000011));
    prog.push_back(stype(12'd1, 5'd6, 5'd5, 3'b000));                   // sb
    prog.push_back(stype(12'd14, 5'd6, 5'd5, 3'b001));                  // sh
    prog.push_back(stype(12'd20, 5'd6, 5'd5, 3'b010));                  // sw
    prog.push_back(stype(12'd24, 5'd6, 5'd5, 3'b011));                  // sd
    prog.push_back(itype(12'd29, 5'd5, 3'b100, 5'd10, 7'b0000011));     // lbu
    prog.push_back(itype(12'd26, 5'd5, 3'b001, 5'd11, 7'b0000011));     // lh
    prog.push_back(itype(12'd30, 5'd5, 3'b101, 5'd12, 7'b0000011));     // lhu
    prog.push_back(itype(12'd28, 5'd5, 3'b010, 5'd13, 7'b0000011));     // lw
    prog.push_back(itype(12'd24, 5'd5, 3'b011, 5'd14, 7'b0000011));     // ld
    for (int r = 10; r <= 14; r++) begin
      prog.push_back(stype(12'(32 + 8 * (r - 10)), 5'(r), 5'd5, 3'b011));
    end
    prog.push_back(32'h0010_0073);
    start_program();
    dmem[16] = p;
    wait_halt();
    check_mem(BASE + 0, merge_lane(fill_word(BASE + 0), p, 1, 1), "sb");
    check_mem(BASE + 8, merge_lane(fill_word(BASE + 8), p, 2, 6), "sh");
    check_mem(BASE + 16, merge_lane(fill_word(BASE + 16), p, 4, 4), "sw");
    check_mem(BASE + 24, p, "sd");
    check_mem(BASE + 32, extract(p, 5, 1, 1'b0), "lbu");
    check_mem(BASE + 40, extract(p, 2, 2, 1'b1), "lh");
    check_mem(BASE + 48, extract(p, 6, 2, 1'b0), "lhu");
    check_mem(BASE + 56, extract(p, 4, 4, 1'b1), "lw");
    check_mem(BASE + 64, p, "ld");
  endtask

  task automatic test_branch();
    int exp_idx [$];
    exp_idx = '{0, 1, 2, 3, 5, 6, 8, 9, 11, 12, 15, 16, 18, 19, 20};
    prog.delete();
    prog.push_back(utype(20'h00001, 5'd5, 7'b0110111));
    prog.push_back(itype(12'd5, 5'd0, 3'b000, 5'd6, 7'b0010011));
    prog.push_back(itype(12'hFFF, 5'd0, 3'b000, 5'd7, 7'b0010011));     // x7 = all ones
    prog.push_back(btype(13'd8, 5'd6, 5'd6, 3'b000));                   // beq taken
    prog.push_back(itype(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
    prog.push_back(btype(13'd8, 5'd6, 5'd6, 3'b001));                   // bne not taken
    prog.push_back(btype(13'd8, 5'd7, 5'd6, 3'b110));                   // bltu taken
    prog.push_back(itype(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
    prog.push_back(btype(13'd8, 5'd7, 5'd6, 3'b111));                   // bgeu not taken
    prog.push_back(btype(13'd8, 5'd6, 5'd7, 3'b111));                   // bgeu taken
    prog.push_back(itype(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
    prog.push_back(btype(13'd8, 5'd6, 5'd7, 3'b110));                   // bltu not taken
    prog.push_back(jtype(21'd12, 5'd1));
    prog.push_back(itype(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
    prog.push_back(itype(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
    prog.push_back(utype(20'h00000, 5'd2, 7'b0010111));                  // auipc x2
    prog.push_back(itype(12'd13, 5'd2, 3'b000, 5'd3, 7'b1100111));      // odd target
    prog.push_back(itype(12'd1, 5'd0, 3'b000, 5'd20, 7'b0010011));
    prog.push_back(stype(12'd0, 5'd1, 5'd5, 3'b011));
    prog.push_back(stype(12'd8, 5'd3, 5'd5, 3'b011));
    prog.push_back(32'h0010_0073);
    tracing = 1'b1;
    start_program();
    wait_halt();
    tracing = 1'b0;
    if (trace.size() != exp_idx.size()) begin
      other_errs++;
      $display("branch test executed %0d instructions instead of %0d",
               trace.size(), exp_idx.size());
    end else begin
      foreach (exp_idx[i]) begin
        check_pc(trace[i], pc_at(exp_idx[i]), "branch trace");
      end
    end
    check_mem(BASE + 0, pc_at(13), "jal link");
    check_mem(BASE + 8, pc_at(17), "jalr link");
  endtask

  task automatic test_halt();
    prog.delete();
    prog.push_back(utype(20'h00001, 5'd5, 7'b0110111));
    prog.push_back(itype(12'd42, 5'd0, 3'b000, 5'd6, 7'b0010011));
    prog.push_back(stype(12'd0, 5'd6, 5'd5, 3'b011));
    prog.push_back(32'h0010_0073);
    prog.push_back(stype(12'd0, 5'd0, 5'd5, 3'b011));                   // must not run
    prog.push_back(stype(12'd8, 5'd0, 5'd5, 3'b011));
    start_program();
    wait_halt();
    imem[3] = stype(12'd8, 5'd6, 5'd5, 3'b011);   // store under the parked pc
    repeat (5) begin
      check_halt(o_halt, 1'b1, "after ebreak");
      check_pc(o_pc, pc_at(3), "after ebreak");
      @(posedge i_clk);
      #1;
    end
    check_mem(BASE + 0, 64'd42, "store before ebreak");
    check_mem(BASE + 8, fill_word(BASE + 8), "store after ebreak");
  endtask

  initial begin
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_inst     = 32'h0000_0013;
    tracing    = 1'b0;
    val_errs   = 0;
    other_errs = 0;
    cycles     = 0;
    rng        = 64'd36;
    test_reset();
    test_alu();
    test_word_ops();
    test_mem();
    test_branch();
    test_halt();
    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/rv_pkg.sv
idu/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_ifu.sv
hdl/rv_core.sv
test/core_asserts.sv
test/tb_core.sv
